// ==== all.f ====
+incdir+include
logic/cim_pkg.sv
logic/params_mem.sv
logic/int_res_mem.sv
logic/mac_unit.sv
logic/cim_ctrl.sv
logic/cim_top.sv
tests/cim_props.sv
tests/tb_cim_top.sv

// ==== Bender.yml ====
package:
  name: cim_frontend

export_include_dirs:
  - include

sources:
  - logic/cim_pkg.sv
  - logic/params_mem.sv
  - logic/int_res_mem.sv
  - logic/mac_unit.sv
  - logic/cim_ctrl.sv
  - logic/cim_top.sv
  - target: test
    files:
      - tests/cim_props.sv
      - tests/tb_cim_top.sv

// ==== tests/tb_cim_top.sv ====
`timescale 1ns/1ps
`include "cim_defs.svh"

module tb_cim_top;
    localparam int NUM_CASES    = 4;
    localparam int NUM_SMP      = `CIM_PATCH_LEN * `CIM_NUM_PATCHES;
    localparam int NUM_KW       = `CIM_PATCH_LEN * `CIM_EMB_DEPTH;
    localparam int NUM_RES      = `CIM_NUM_PATCHES * `CIM_EMB_DEPTH;
    localparam int DONE_TIMEOUT = 400;

    logic                   clk;
    logic                   rst_n;
    logic                   start_eeg_load_i;
    logic                   new_sleep_epoch_i;
    logic                   new_eeg_data_i;
    cim_pkg::eeg_sample_t   eeg_i;
    logic                   param_wr_en_i;
    cim_pkg::param_addr_t   param_wr_addr_i;
    cim_pkg::comp_fx_t      param_wr_data_i;
    logic                   res_rd_en_i;
    cim_pkg::int_res_addr_t res_rd_addr_i;
    cim_pkg::comp_fx_t      res_rd_data_o;
    logic                   inference_complete_o;

    // One row per epoch case
    string                tbl_name   [NUM_CASES];
    cim_pkg::eeg_sample_t tbl_eeg    [NUM_CASES][NUM_SMP];
    cim_pkg::comp_fx_t    tbl_kernel [NUM_CASES][NUM_KW];
    cim_pkg::comp_fx_t    tbl_bias   [NUM_CASES][`CIM_EMB_DEPTH];
    cim_pkg::comp_fx_t    tbl_exp    [NUM_CASES][NUM_RES];

    int seed;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    cim_top i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Dot product at accumulator width, fraction shift, bias add, truncate
    function automatic cim_pkg::comp_fx_t proj_model(input int c, input int p, input int r);
        int acc;
        int data_word;
        int k;
        acc = 0;
        for (k = 0; k < `CIM_PATCH_LEN; k++) begin
            data_word = int'(tbl_eeg[c][p * `CIM_PATCH_LEN + k])
                        * (2 ** (`CIM_FRAC_BITS - `CIM_ADC_W));
            acc += data_word * int'(tbl_kernel[c][r * `CIM_PATCH_LEN + k]);
        end
        return cim_pkg::comp_fx_t'((acc >>> `CIM_FRAC_BITS) + int'(tbl_bias[c][r]));
    endfunction

    function automatic cim_pkg::comp_fx_t eeg_expected(input cim_pkg::eeg_sample_t s);
        return cim_pkg::comp_fx_t'(int'(s) * (2 ** (`CIM_FRAC_BITS - `CIM_ADC_W)));
    endfunction

    task automatic fill_table();
        int c;
        int i;
        tbl_name[0] = "random_a";
        tbl_name[1] = "neg_full_scale";
        tbl_name[2] = "pos_truncation";
        tbl_name[3] = "random_b";
        for (c = 0; c < NUM_CASES; c++) begin
            // Cases 1 and 2 are hand-written edge values
            for (i = 0; i < NUM_SMP; i++) begin
                tbl_eeg[c][i] = (c == 1 || c == 2) ? 8'hff : 8'($random(seed));
            end
            for (i = 0; i < NUM_KW; i++) begin
                tbl_kernel[c][i] = (c == 1) ? 16'h8000 : (c == 2) ? 16'h7fff : 16'($random(seed));
            end
            for (i = 0; i < `CIM_EMB_DEPTH; i++) begin
                tbl_bias[c][i] = (c == 1) ? 16'h8000 : (c == 2) ? 16'h7fff : 16'($random(seed));
            end
            for (i = 0; i < NUM_RES; i++) begin
                tbl_exp[c][i] = proj_model(c, i / `CIM_EMB_DEPTH, i % `CIM_EMB_DEPTH);
            end
        end
    endtask

    task automatic write_param(input int addr, input cim_pkg::comp_fx_t data);
        @(negedge clk);
        param_wr_en_i   = 1'b1;
        param_wr_addr_i = cim_pkg::param_addr_t'(addr);
        param_wr_data_i = data;
        @(negedge clk);
        param_wr_en_i = 1'b0;
    endtask

    task automatic load_case(input int c);
        int i;
        for (i = 0; i < NUM_KW; i++) begin
            write_param(`CIM_KERNEL_BASE + i, tbl_kernel[c][i]);
        end
        for (i = 0; i < `CIM_EMB_DEPTH; i++) begin
            write_param(`CIM_BIAS_BASE + i, tbl_bias[c][i]);
        end
        @(negedge clk);
        start_eeg_load_i = 1'b1;
        @(negedge clk);
        start_eeg_load_i = 1'b0;
        for (i = 0; i < NUM_SMP; i++) begin
            new_eeg_data_i = 1'b1;
            eeg_i          = tbl_eeg[c][i];
            @(negedge clk);
        end
        new_eeg_data_i = 1'b0;
    endtask

    task automatic read_word(input int addr, output cim_pkg::comp_fx_t data);
        @(negedge clk);
        res_rd_en_i   = 1'b1;
        res_rd_addr_i = cim_pkg::int_res_addr_t'(addr);
        @(negedge clk);
        res_rd_en_i = 1'b0;
        data        = res_rd_data_o;
    endtask

    task automatic check_word(input int addr, input cim_pkg::comp_fx_t exp);
        cim_pkg::comp_fx_t got;
        read_word(addr, got);
        assert (got === exp) else begin
            $display("[FAIL] res_rd_data_o @0x%02h: expected 0x%04h, got 0x%04h", addr, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_eeg(input int c);
        int i;
        for (i = 0; i < NUM_SMP; i++) begin
            check_word(`CIM_EEG_BASE + i, eeg_expected(tbl_eeg[c][i]));
        end
    endtask

    task automatic run_epoch();
        int  cyc;
        logic seen;
        seen = 1'b0;
        @(negedge clk);
        new_sleep_epoch_i = 1'b1;
        @(negedge clk);
        new_sleep_epoch_i = 1'b0;
        for (cyc = 0; cyc < DONE_TIMEOUT && !seen; cyc++) begin
            // Stray sample strobes while inference runs
            new_eeg_data_i = cyc[0];
            eeg_i          = 8'($random(seed));
            @(negedge clk);
            seen = inference_complete_o;
        end
        new_eeg_data_i = 1'b0;
        assert (seen) else begin
            $display("inference_complete_o did not pulse within %0d cycles", DONE_TIMEOUT);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%-34s ok", name);
        end else begin
            tests_failed++;
            $display("%-34s %0d errors", name, test_errors);
        end
        errors      += test_errors;
        test_errors  = 0;
    endtask

    initial begin
        int c;
        int i;
        rst_n             = 1'b0;
        start_eeg_load_i  = 1'b0;
        new_sleep_epoch_i = 1'b0;
        new_eeg_data_i    = 1'b0;
        eeg_i             = '0;
        param_wr_en_i     = 1'b0;
        param_wr_addr_i   = '0;
        param_wr_data_i   = '0;
        res_rd_en_i       = 1'b0;
        res_rd_addr_i     = '0;
        seed              = 32'ha374_82cc;
        errors            = 0;
        test_errors       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        fill_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!inference_complete_o) else begin
                $display("[FAIL] inference_complete_o: expected 0x0, got 0x%0h",
                         inference_complete_o);
                test_errors++;
            end
        end
        finish_test("reset_idle");

        // Later cases overwrite the results of earlier ones
        for (c = 0; c < NUM_CASES; c++) begin
            load_case(c);
            check_eeg(c);
            finish_test($sformatf("case%0d_%s_eeg_load", c, tbl_name[c]));
            run_epoch();
            for (i = 0; i < NUM_RES; i++) begin
                check_word(`CIM_PATCH_BASE + i, tbl_exp[c][i]);
            end
            finish_test($sformatf("case%0d_%s_projection", c, tbl_name[c]));
            check_eeg(c);
            finish_test($sformatf("case%0d_%s_eeg_hold", c, tbl_name[c]));
        end

        test_errors += i_dut.i_props.fail_cnt;
        finish_test("bound_assertions");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/cim_props.sv ====
`timescale 1ns/1ps

module cim_props (
    input logic              clk,
    input logic              rst_n,
    input logic              res_rd_en_i,
    input cim_pkg::comp_fx_t res_rd_data_o,
    input logic              inference_complete_o
);
    // Count of assertion failures
    int fail_cnt = 0;

    // Completion is a single-cycle pulse
    complete_single: assert property (@(posedge clk) disable iff (!rst_n)
        inference_complete_o |=> !inference_complete_o)
        else begin
            $error("inference_complete_o high for two cycles in a row");
            fail_cnt++;
        end

    complete_reset: assert property (@(posedge clk) !rst_n |=> !inference_complete_o)
        else begin
            $error("inference_complete_o high in the cycle after reset");
            fail_cnt++;
        end

    // Readout register holds without an enable
    readout_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!res_rd_en_i && !$isunknown(res_rd_data_o)) |=> $stable(res_rd_data_o))
        else begin
            $error("res_rd_data_o changed without res_rd_en_i");
            fail_cnt++;
        end

endmodule

bind cim_top cim_props i_props (.*);

// ==== logic/cim_top.sv ====
`timescale 1ns/1ps

module cim_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_eeg_load_i,
    input  logic                   new_sleep_epoch_i,
    input  logic                   new_eeg_data_i,
    input  cim_pkg::eeg_sample_t   eeg_i,
    input  logic                   param_wr_en_i,
    input  cim_pkg::param_addr_t   param_wr_addr_i,
    input  cim_pkg::comp_fx_t      param_wr_data_i,
    input  logic                   res_rd_en_i,
    input  cim_pkg::int_res_addr_t res_rd_addr_i,
    output cim_pkg::comp_fx_t      res_rd_data_o,
    output logic                   inference_complete_o
);
    // Controller to MAC
    logic                   mac_start;
    cim_pkg::int_res_addr_t mac_addr_data;
    cim_pkg::param_addr_t   mac_addr_kernel;
    cim_pkg::param_addr_t   mac_addr_bias;
    cim_pkg::vec_len_t      mac_len;
    logic                   mac_busy;
    logic                   mac_done;
    cim_pkg::comp_fx_t      mac_out;

    // Controller write port into intermediate results
    logic                   wr_en;
    cim_pkg::int_res_addr_t wr_addr;
    cim_pkg::comp_fx_t      wr_data;

    // MAC read ports
    logic                   prm_rd_en;
    cim_pkg::param_addr_t   prm_rd_addr;
    cim_pkg::comp_fx_t      prm_rd_data;
    logic                   res_rd_en;
    cim_pkg::int_res_addr_t res_rd_addr;
    cim_pkg::comp_fx_t      res_rd_data;

    cim_ctrl i_ctrl (
        .clk, .rst_n, .start_eeg_load_i, .new_sleep_epoch_i, .new_eeg_data_i, .eeg_i,
        .mac_start_o(mac_start), .mac_addr_data_o(mac_addr_data),
        .mac_addr_kernel_o(mac_addr_kernel), .mac_addr_bias_o(mac_addr_bias),
        .mac_len_o(mac_len), .mac_busy_i(mac_busy), .mac_done_i(mac_done),
        .mac_out_i(mac_out), .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .inference_complete_o
    );

    mac_unit i_mac (
        .clk, .rst_n, .start_i(mac_start), .addr_data_i(mac_addr_data),
        .addr_kernel_i(mac_addr_kernel), .addr_bias_i(mac_addr_bias), .len_i(mac_len),
        .busy_o(mac_busy), .done_o(mac_done), .out_o(mac_out),
        .prm_rd_en_o(prm_rd_en), .prm_rd_addr_o(prm_rd_addr), .prm_rd_data_i(prm_rd_data),
        .res_rd_en_o(res_rd_en), .res_rd_addr_o(res_rd_addr), .res_rd_data_i(res_rd_data)
    );

    params_mem i_params_mem (
        .clk, .wr_en_i(param_wr_en_i), .wr_addr_i(param_wr_addr_i),
        .wr_data_i(param_wr_data_i), .rd_en_i(prm_rd_en), .rd_addr_i(prm_rd_addr),
        .rd_data_o(prm_rd_data)
    );

    // Port A serves the MAC, port B the external readout
    int_res_mem i_int_res_mem (
        .clk, .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_a_en_i(res_rd_en), .rd_a_addr_i(res_rd_addr), .rd_a_data_o(res_rd_data),
        .rd_b_en_i(res_rd_en_i), .rd_b_addr_i(res_rd_addr_i), .rd_b_data_o(res_rd_data_o)
    );

endmodule

// ==== logic/cim_ctrl.sv ====
`timescale 1ns/1ps
`include "cim_defs.svh"

module cim_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_eeg_load_i,
    input  logic                   new_sleep_epoch_i,
    input  logic                   new_eeg_data_i,
    input  cim_pkg::eeg_sample_t   eeg_i,
    output logic                   mac_start_o,
    output cim_pkg::int_res_addr_t mac_addr_data_o,
    output cim_pkg::param_addr_t   mac_addr_kernel_o,
    output cim_pkg::param_addr_t   mac_addr_bias_o,
    output cim_pkg::vec_len_t      mac_len_o,
    input  logic                   mac_busy_i,
    input  logic                   mac_done_i,
    input  cim_pkg::comp_fx_t      mac_out_i,
    output logic                   wr_en_o,
    output cim_pkg::int_res_addr_t wr_addr_o,
    output cim_pkg::comp_fx_t      wr_data_o,
    output logic                   inference_complete_o
);
    cim_pkg::cim_state_t  state;
    cim_pkg::proj_phase_t phase;

    // EEG load position
    cim_pkg::vec_len_t smp_cnt;
    cim_pkg::vec_len_t load_patch_cnt;

    // Projection position
    cim_pkg::vec_len_t row_cnt;
    cim_pkg::vec_len_t proj_patch_cnt;

    logic last_smp;
    logic last_load_patch;
    logic last_row;
    logic last_proj_patch;

    assign last_smp        = (smp_cnt == `CIM_PATCH_LEN - 1);
    assign last_load_patch = (load_patch_cnt == `CIM_NUM_PATCHES - 1);
    assign last_row        = (row_cnt == `CIM_EMB_DEPTH - 1);
    assign last_proj_patch = (proj_patch_cnt == `CIM_NUM_PATCHES - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                <= cim_pkg::CIM_IDLE;
            phase                <= cim_pkg::PROJ_ISSUE;
            smp_cnt              <= '0;
            load_patch_cnt       <= '0;
            row_cnt              <= '0;
            proj_patch_cnt       <= '0;
            mac_start_o          <= 1'b0;
            wr_en_o              <= 1'b0;
            inference_complete_o <= 1'b0;
        end else begin
            mac_start_o          <= 1'b0;
            wr_en_o              <= 1'b0;
            inference_complete_o <= 1'b0;

            if (state == cim_pkg::CIM_INFERENCE) begin
                case (phase)
                    cim_pkg::PROJ_ISSUE: begin
                        if (!mac_busy_i) begin
                            mac_start_o       <= 1'b1;
                            mac_addr_data_o   <= cim_pkg::int_res_addr_t'(`CIM_EEG_BASE
                                                 + proj_patch_cnt * `CIM_PATCH_LEN);
                            mac_addr_kernel_o <= cim_pkg::param_addr_t'(`CIM_KERNEL_BASE
                                                 + row_cnt * `CIM_PATCH_LEN);
                            mac_addr_bias_o   <= cim_pkg::param_addr_t'(`CIM_BIAS_BASE + row_cnt);
                            mac_len_o         <= cim_pkg::vec_len_t'(`CIM_PATCH_LEN);
                            phase             <= cim_pkg::PROJ_WAIT;
                        end
                    end
                    cim_pkg::PROJ_WAIT: begin
                        if (mac_done_i) begin
                            wr_en_o   <= 1'b1;
                            wr_addr_o <= cim_pkg::int_res_addr_t'(`CIM_PATCH_BASE
                                         + proj_patch_cnt * `CIM_EMB_DEPTH + row_cnt);
                            wr_data_o <= mac_out_i;
                            // Rows inner, patches outer
                            row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                            if (last_row) begin
                                proj_patch_cnt <= last_proj_patch ? '0 : proj_patch_cnt + 1'b1;
                            end
                            phase <= (last_row && last_proj_patch) ? cim_pkg::PROJ_DONE
                                                                    : cim_pkg::PROJ_ISSUE;
                        end
                    end
                    cim_pkg::PROJ_DONE: begin
                        inference_complete_o <= 1'b1;
                        state                <= cim_pkg::CIM_IDLE;
                        phase                <= cim_pkg::PROJ_ISSUE;
                    end
                    default: begin
                        phase <= cim_pkg::PROJ_ISSUE;
                    end
                endcase
            end else if (new_sleep_epoch_i) begin
                state          <= cim_pkg::CIM_INFERENCE;
                phase          <= cim_pkg::PROJ_ISSUE;
                row_cnt        <= '0;
                proj_patch_cnt <= '0;
            end else if (state == cim_pkg::CIM_IDLE) begin
                if (start_eeg_load_i) begin
                    state <= cim_pkg::CIM_EEG_LOAD;
                end
            end else if (new_eeg_data_i) begin
                wr_en_o   <= 1'b1;
                wr_addr_o <= cim_pkg::int_res_addr_t'(`CIM_EEG_BASE
                             + load_patch_cnt * `CIM_PATCH_LEN + smp_cnt);
                // Samples land in [0, 1)
                wr_data_o <= cim_pkg::comp_fx_t'(eeg_i) << (`CIM_FRAC_BITS - `CIM_ADC_W);
                smp_cnt   <= last_smp ? '0 : smp_cnt + 1'b1;
                if (last_smp) begin
                    load_patch_cnt <= last_load_patch ? '0 : load_patch_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/mac_unit.sv ====
`timescale 1ns/1ps
`include "cim_defs.svh"

module mac_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  cim_pkg::int_res_addr_t addr_data_i,
    input  cim_pkg::param_addr_t   addr_kernel_i,
    input  cim_pkg::param_addr_t   addr_bias_i,
    input  cim_pkg::vec_len_t      len_i,
    output logic                   busy_o,
    output logic                   done_o,
    output cim_pkg::comp_fx_t      out_o,
    output logic                   prm_rd_en_o,
    output cim_pkg::param_addr_t   prm_rd_addr_o,
    input  cim_pkg::comp_fx_t      prm_rd_data_i,
    output logic                   res_rd_en_o,
    output cim_pkg::int_res_addr_t res_rd_addr_o,
    input  cim_pkg::comp_fx_t      res_rd_data_i
);
    cim_pkg::mac_state_t    state;
    cim_pkg::int_res_addr_t data_base;
    cim_pkg::param_addr_t   kernel_base;
    cim_pkg::param_addr_t   bias_addr;
    cim_pkg::vec_len_t      len;
    cim_pkg::vec_len_t      idx;
    logic                   rd_valid;
    cim_pkg::acc_t          acc;
    cim_pkg::acc_t          prod;
    cim_pkg::acc_t          result;

    // One element pair per cycle while reading, bias in the cycle after
    assign res_rd_en_o   = (state == cim_pkg::MAC_READ);
    assign res_rd_addr_o = data_base + cim_pkg::int_res_addr_t'(idx);
    assign prm_rd_en_o   = (state == cim_pkg::MAC_READ) || (state == cim_pkg::MAC_BIAS);
    assign prm_rd_addr_o = (state == cim_pkg::MAC_BIAS) ? bias_addr
                                                        : kernel_base + cim_pkg::param_addr_t'(idx);

    assign prod   = cim_pkg::acc_t'(res_rd_data_i) * cim_pkg::acc_t'(prm_rd_data_i);
    // Bias word sits on the param read data during MAC_OUT
    assign result = (acc >>> `CIM_FRAC_BITS) + cim_pkg::acc_t'(prm_rd_data_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= cim_pkg::MAC_IDLE;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            rd_valid <= 1'b0;
            idx      <= '0;
        end else begin
            done_o   <= 1'b0;
            rd_valid <= (state == cim_pkg::MAC_READ);
            case (state)
                cim_pkg::MAC_IDLE: begin
                    if (start_i) begin
                        state  <= cim_pkg::MAC_READ;
                        busy_o <= 1'b1;
                        idx    <= '0;
                    end
                end
                cim_pkg::MAC_READ: begin
                    if (idx == len - 1'b1) begin
                        state <= cim_pkg::MAC_BIAS;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                cim_pkg::MAC_BIAS: begin
                    state <= cim_pkg::MAC_OUT;
                end
                default: begin
                    state  <= cim_pkg::MAC_IDLE;
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cim_pkg::MAC_IDLE && start_i) begin
            data_base   <= addr_data_i;
            kernel_base <= addr_kernel_i;
            bias_addr   <= addr_bias_i;
            len         <= len_i;
            acc         <= '0;
        end else if (rd_valid) begin
            acc <= acc + prod;
        end
        if (state == cim_pkg::MAC_OUT) begin
            out_o <= cim_pkg::comp_fx_t'(result);
        end
    end

endmodule

// ==== logic/int_res_mem.sv ====
`timescale 1ns/1ps
`include "cim_defs.svh"

module int_res_mem #(
    parameter int DEPTH = `CIM_INT_RES_DEPTH
) (
    input  logic                   clk,
    input  logic                   wr_en_i,
    input  cim_pkg::int_res_addr_t wr_addr_i,
    input  cim_pkg::comp_fx_t      wr_data_i,
    input  logic                   rd_a_en_i,
    input  cim_pkg::int_res_addr_t rd_a_addr_i,
    output cim_pkg::comp_fx_t      rd_a_data_o,
    input  logic                   rd_b_en_i,
    input  cim_pkg::int_res_addr_t rd_b_addr_i,
    output cim_pkg::comp_fx_t      rd_b_data_o
);
    cim_pkg::comp_fx_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Two independent registered reads
    always_ff @(posedge clk) begin
        if (rd_a_en_i) begin
            rd_a_data_o <= mem[rd_a_addr_i];
        end
        if (rd_b_en_i) begin
            rd_b_data_o <= mem[rd_b_addr_i];
        end
    end

endmodule

// ==== logic/params_mem.sv ====
`timescale 1ns/1ps
`include "cim_defs.svh"

module params_mem #(
    parameter int DEPTH = `CIM_PARAM_DEPTH
) (
    input  logic                 clk,
    input  logic                 wr_en_i,
    input  cim_pkg::param_addr_t wr_addr_i,
    input  cim_pkg::comp_fx_t    wr_data_i,
    input  logic                 rd_en_i,
    input  cim_pkg::param_addr_t rd_addr_i,
    output cim_pkg::comp_fx_t    rd_data_o
);
    cim_pkg::comp_fx_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read data holds until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== logic/cim_pkg.sv ====
`include "cim_defs.svh"

package cim_pkg;

    typedef logic signed [`CIM_COMP_W-1:0] comp_fx_t;
    typedef logic signed [`CIM_ACC_W-1:0] acc_t;
    typedef logic [`CIM_ADC_W-1:0] eeg_sample_t;
    typedef logic [$clog2(`CIM_PARAM_DEPTH)-1:0] param_addr_t;
    typedef logic [$clog2(`CIM_INT_RES_DEPTH)-1:0] int_res_addr_t;
    typedef logic [7:0] vec_len_t;

    typedef enum logic [1:0] {CIM_IDLE, CIM_EEG_LOAD, CIM_INFERENCE} cim_state_t;

    // Projection sub-steps inside CIM_INFERENCE
    typedef enum logic [1:0] {PROJ_ISSUE, PROJ_WAIT, PROJ_DONE} proj_phase_t;

    typedef enum logic [1:0] {MAC_IDLE, MAC_READ, MAC_BIAS, MAC_OUT} mac_state_t;

endpackage

// ==== include/cim_defs.svh ====
`ifndef CIM_DEFS_SVH
`define CIM_DEFS_SVH

// Fixed-point format shared by all stored values
`define CIM_COMP_W        16
`define CIM_FRAC_BITS     10
`define CIM_ADC_W         8
`define CIM_ACC_W         32

// Model dimensions
`define CIM_PATCH_LEN     4
`define CIM_NUM_PATCHES   3
`define CIM_EMB_DEPTH     4

// Memory depths and regions
`define CIM_PARAM_DEPTH   64
`define CIM_INT_RES_DEPTH 64
`define CIM_EEG_BASE      0
`define CIM_PATCH_BASE    32
`define CIM_KERNEL_BASE   0
`define CIM_BIAS_BASE     32

`endif
